// ==== dv/ex_vectors.svh ====
//****************************************************************************
// Execute-stage directed vectors
// One row per instruction with the writeback it must produce
//****************************************************************************
// columns: name, op, rs, rt, imm, shamt, rt addr, rd addr,
//          expected valid, expected dest, expected value, expected overflow
task automatic load_vectors;
    add_row("nop", ex_isa_pkg::NOP, 'h0, 'h0, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    // add, subtract, compare
    add_row("addu", ex_isa_pkg::ADDU, 'hFFFFFFFF, 'h2, 'h0, 0, 2, 3, 1, 3, 'h1, 0);
    add_row("subu", ex_isa_pkg::SUBU, 'h0, 'h1, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFF, 0);
    add_row("add", ex_isa_pkg::ADD, 'h5, 'hFFFFFFFD, 'h0, 0, 2, 3, 1, 3, 'h2, 0);
    add_row("add_ov", ex_isa_pkg::ADD, 'h7FFFFFFF, 'h1, 'h0, 0, 2, 3, 1, 0, 'h0, 1);
    add_row("sub_ov", ex_isa_pkg::SUB, 'h80000000, 'h1, 'h0, 0, 2, 3, 1, 0, 'h0, 1);
    add_row("addi", ex_isa_pkg::ADDI, 'h10, 'h0, 'hFFFF, 0, 4, 5, 1, 4, 'hF, 0);
    add_row("addi_ov", ex_isa_pkg::ADDI, 'h7FFFFFF0, 'h0, 'h0010, 0, 4, 5, 1, 0, 'h0, 1);
    add_row("slt", ex_isa_pkg::SLT, 'hFFFFFFFF, 'h1, 'h0, 0, 2, 3, 1, 3, 'h1, 0);
    add_row("sltu", ex_isa_pkg::SLTU, 'hFFFFFFFF, 'h1, 'h0, 0, 2, 3, 1, 3, 'h0, 0);
    add_row("slti", ex_isa_pkg::SLTI, 'hFFFFFFFF, 'h0, 'h0001, 0, 4, 5, 1, 4, 'h1, 0);
    add_row("sltiu", ex_isa_pkg::SLTIU, 'hFFFFFFFF, 'h0, 'h0001, 0, 4, 5, 1, 4, 'h0, 0);
    // logic, LUI, conditional moves
    add_row("and", ex_isa_pkg::AND, 'hF0F0F0F0, 'hFF00FF00, 'h0, 0, 2, 3, 1, 3, 'hF000F000, 0);
    add_row("or", ex_isa_pkg::OR, 'hF0F0F0F0, 'hFF00FF00, 'h0, 0, 2, 3, 1, 3, 'hFFF0FFF0, 0);
    add_row("xor", ex_isa_pkg::XOR, 'hF0F0F0F0, 'hFF00FF00, 'h0, 0, 2, 3, 1, 3, 'h0FF00FF0, 0);
    add_row("nor", ex_isa_pkg::NOR, 'hF0F0F0F0, 'hFF00FF00, 'h0, 0, 2, 3, 1, 3, 'h000F000F, 0);
    add_row("andi", ex_isa_pkg::ANDI, 'hFFFFFFFF, 'h0, 'h8001, 0, 4, 5, 1, 4, 'h00008001, 0);
    // rs shares set bits with the immediate so OR and XOR differ
    add_row("ori", ex_isa_pkg::ORI, 'h1234800F, 'h0, 'h8001, 0, 4, 5, 1, 4, 'h1234800F, 0);
    add_row("xori", ex_isa_pkg::XORI, 'hFFFFFFFF, 'h0, 'h8000, 0, 4, 5, 1, 4, 'hFFFF7FFF, 0);
    add_row("lui", ex_isa_pkg::LUI, 'h0, 'h0, 'hABCD, 0, 4, 5, 1, 4, 'hABCD0000, 0);
    add_row("movz_t", ex_isa_pkg::MOVZ, 'h11111111, 'h0, 'h0, 0, 2, 3, 1, 3, 'h11111111, 0);
    add_row("movz_f", ex_isa_pkg::MOVZ, 'h11111111, 'h5, 'h0, 0, 2, 3, 1, 0, 'h0, 0);
    add_row("movn_t", ex_isa_pkg::MOVN, 'h22222222, 'h5, 'h0, 0, 2, 3, 1, 3, 'h22222222, 0);
    add_row("movn_f", ex_isa_pkg::MOVN, 'h22222222, 'h0, 'h0, 0, 2, 3, 1, 0, 'h0, 0);
    // shifts on a negative word, variable forms use rs bits 4 to 0 only
    add_row("sll", ex_isa_pkg::SLL, 'h0, 'hF0000010, 'h0, 4, 2, 3, 1, 3, 'h00000100, 0);
    add_row("srl", ex_isa_pkg::SRL, 'h0, 'hF0000010, 'h0, 4, 2, 3, 1, 3, 'h0F000001, 0);
    add_row("sra", ex_isa_pkg::SRA, 'h0, 'hF0000010, 'h0, 4, 2, 3, 1, 3, 'hFF000001, 0);
    add_row("sllv", ex_isa_pkg::SLLV, 'h24, 'hF0000010, 'h0, 0, 2, 3, 1, 3, 'h00000100, 0);
    add_row("srlv", ex_isa_pkg::SRLV, 'hFFFFFFE4, 'hF0000010, 'h0, 0, 2, 3, 1, 3, 'h0F000001, 0);
    add_row("srav", ex_isa_pkg::SRAV, 'h44, 'hF0000010, 'h0, 0, 2, 3, 1, 3, 'hFF000001, 0);
    add_row("clz_0", ex_isa_pkg::CLZ, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h20, 0);
    add_row("clz_1", ex_isa_pkg::CLZ, 'hFFFFFFFF, 'h0, 'h0, 0, 2, 3, 1, 3, 'h0, 0);
    add_row("clz_b", ex_isa_pkg::CLZ, 'h00010000, 'h0, 'h0, 0, 2, 3, 1, 3, 'hF, 0);
    add_row("clo_1", ex_isa_pkg::CLO, 'hFFFFFFFF, 'h0, 'h0, 0, 2, 3, 1, 3, 'h20, 0);
    add_row("clo_0", ex_isa_pkg::CLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h0, 0);
    add_row("clo_b", ex_isa_pkg::CLO, 'hFFFF7FFF, 'h0, 'h0, 0, 2, 3, 1, 3, 'h10, 0);
    // HI/LO moves, multiply and accumulate
    add_row("mthi", ex_isa_pkg::MTHI, 'hCAFEF00D, 'h0, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("mtlo", ex_isa_pkg::MTLO, 'h12345678, 'h0, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("mfhi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hCAFEF00D, 0);
    add_row("mflo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h12345678, 0);
    add_row("mult", ex_isa_pkg::MULT, 'hFFFFFFFE, 'hFFFFFFFD, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("mult_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h0, 0);
    add_row("mult_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h6, 0);
    add_row("multu", ex_isa_pkg::MULTU, 'hFFFFFFFF, 'hFFFFFFFF, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("multu_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFE, 0);
    add_row("multu_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h1, 0);
    add_row("mul", ex_isa_pkg::MUL, 'hFFFFFFFF, 'h7, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFF9, 0);
    add_row("madd", ex_isa_pkg::MADD, 'h2, 'h3, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("madd_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h7, 0);
    add_row("msub", ex_isa_pkg::MSUB, 'hFFFFFFFF, 'h2, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("msub_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFE, 0);
    add_row("msub_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h9, 0);
    // divide, each read-back row is issued while the divider stalls
    add_row("div", ex_isa_pkg::DIV, 'hFFFFFFF9, 'h2, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("div_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFD, 0);
    add_row("div_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFF, 0);
    add_row("divu", ex_isa_pkg::DIVU, 'hFFFFFFFF, 'h10, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("divu_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'h0FFFFFFF, 0);
    add_row("divu_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hF, 0);
    add_row("div0", ex_isa_pkg::DIV, 'hFFFFFFF9, 'h0, 'h0, 0, 2, 3, 0, 0, 'h0, 0);
    add_row("div0_lo", ex_isa_pkg::MFLO, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFFF, 0);
    add_row("div0_hi", ex_isa_pkg::MFHI, 'h0, 'h0, 'h0, 0, 2, 3, 1, 3, 'hFFFFFFF9, 0);
endtask

// ==== dv/ex_unit_tb.sv ====
//****************************************************************************
// Execute-stage testbench
// Directed vector table, LFSR-driven ADDU/XOR rows and divide stall checks
//****************************************************************************
`timescale 1ns/1ps

module ex_unit_tb;

    localparam int XLEN = ex_isa_pkg::XLEN;
    localparam int RAND_ROWS = 16;
    // issue plus check, two cycles per random row
    localparam int RAND_CYCLES = RAND_ROWS * 2;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct packed {
        ex_isa_pkg::ex_op_e  op;
        logic [31:0]         rs;
        logic [31:0]         rt;
        logic [15:0]         imm;
        logic [4:0]          shamt;
        logic [4:0]          rt_addr;
        logic [4:0]          rd_addr;
        logic                exp_valid;
        logic [4:0]          exp_dest;
        logic [31:0]         exp_value;
        logic                exp_ovf;
    } vec_t;

    logic                    clk;
    logic                    rst_n;
    ex_pipe_pkg::ex_issue_t  issue;
    logic                    stall;
    ex_pipe_pkg::ex_wb_t     wb;

    vec_t        vecs[$];
    string       names[$];
    int          checks = 0;
    int          errors = 0;
    int          cycles = 0;
    int          cycle_limit;
    logic [31:0] lfsr = 32'd28;
    logic        prev_div;

    ex_unit UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue_i (issue),
        .stall_o (stall),
        .wb_o    (wb)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the stage never finished", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic add_row(input string name, input ex_isa_pkg::ex_op_e op,
                           input logic [31:0] rs, input logic [31:0] rt,
                           input int imm, input int shamt, input int ra_t,
                           input int ra_d, input int valid, input int dest,
                           input logic [31:0] value, input int ovf);
        vec_t v;
        v.op = op;
        v.rs = rs;
        v.rt = rt;
        v.imm = 16'(imm);
        v.shamt = 5'(shamt);
        v.rt_addr = 5'(ra_t);
        v.rd_addr = 5'(ra_d);
        v.exp_valid = valid != 0;
        v.exp_dest = 5'(dest);
        v.exp_value = value;
        v.exp_ovf = ovf != 0;
        vecs.push_back(v);
        names.push_back(name);
    endtask

    `include "ex_vectors.svh"

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp, input logic [31:0] act);
        errors++;
        $display("FAILED %s %s expected %h actual %h", name, field, exp, act);
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic apply_row(input string name, input vec_t v);
        int stall_cycles;
        stall_cycles = 0;
        issue.valid = 1'b1;
        issue.op = v.op;
        issue.rs_val = v.rs;
        issue.rt_val = v.rt;
        issue.imm = v.imm;
        issue.shamt = v.shamt;
        issue.rt_addr = v.rt_addr;
        issue.rd_addr = v.rd_addr;
        // row stays on the bus while the divider runs
        while (stall)
        begin
            stall_cycles++;
            @(negedge clk);
        end
        if (prev_div)
        begin
            checks++;
            if (stall_cycles != XLEN)
                report_mismatch(name, "stall cycles", XLEN, stall_cycles);
        end
        @(negedge clk);
        issue.valid = 1'b0;
        prev_div = (v.op == ex_isa_pkg::DIV) || (v.op == ex_isa_pkg::DIVU);
        checks++;
        if (wb.valid !== v.exp_valid)
            report_mismatch(name, "valid", 32'(v.exp_valid), 32'(wb.valid));
        else if (v.exp_valid)
        begin
            checks += 2;
            if (wb.dest !== v.exp_dest)
                report_mismatch(name, "dest", 32'(v.exp_dest), 32'(wb.dest));
            if (wb.overflow !== v.exp_ovf)
                report_mismatch(name, "overflow", 32'(v.exp_ovf), 32'(wb.overflow));
            // value only matters when a register is written
            if (v.exp_dest != '0)
            begin
                checks++;
                if (wb.value !== v.exp_value)
                    report_mismatch(name, "value", v.exp_value, wb.value);
            end
        end
    endtask

    // right-shifting Galois form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? LFSR_TAPS : 32'h0);
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++)
        begin
            lfsr = lfsr_step(lfsr);
            w = {w[30:0], lfsr[0]};
        end
    endtask

    task automatic run_random;
        vec_t        v;
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < RAND_ROWS; n++)
        begin
            draw_word(a);
            draw_word(b);
            v = '0;
            v.op = (n % 2 == 0) ? ex_isa_pkg::ADDU : ex_isa_pkg::XOR;
            v.rs = a;
            v.rt = b;
            v.rt_addr = 5'd8;
            v.rd_addr = 5'd9;
            v.exp_valid = 1'b1;
            v.exp_dest = 5'd9;
            v.exp_value = (n % 2 == 0) ? a + b : a ^ b;
            apply_row($sformatf("rand%0d", n), v);
        end
    endtask

    initial
    begin
        clk = 1'b0;
        rst_n = 1'b0;
        issue = '0;
        prev_div = 1'b0;
        load_vectors();
        cycle_limit = vecs.size() * (XLEN + 4) + RAND_CYCLES + 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        checks += 2;
        if (wb.valid !== 1'b0)
            report_mismatch("reset", "wb_o.valid", 0, 32'(wb.valid));
        if (stall !== 1'b0)
            report_mismatch("reset", "stall_o", 0, 32'(stall));
        foreach (vecs[i])
            apply_row(names[i], vecs[i]);
        run_random();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== hdl/ex_alu.sv ====
//****************************************************************************
// Execute-stage ALU
// Add/subtract with overflow, compares, logic ops, LUI and conditional moves
//****************************************************************************
`timescale 1ns/1ps

module ex_alu (
    input  ex_pipe_pkg::ex_issue_t          issue_i,
    output logic [ex_isa_pkg::XLEN-1:0]     alu_value_o,
    output logic                            alu_overflow_o,
    output logic                            move_suppress_o
);

    localparam int W = ex_isa_pkg::XLEN;
    localparam int IW = ex_isa_pkg::IMM_W;

    logic [W-1:0] rs;
    logic [W-1:0] rt;
    logic [W-1:0] imm_sx;
    logic [W-1:0] imm_zx;
    logic [W-1:0] opb;
    logic [W-1:0] sum;
    logic         is_sub;
    logic         sign_cond;
    logic         trap_op;
    logic         slt_s;
    logic         slt_u;

    assign rs = issue_i.rs_val;
    assign rt = issue_i.rt_val;
    assign imm_sx = {{(W-IW){issue_i.imm[IW-1]}}, issue_i.imm};
    assign imm_zx = {{(W-IW){1'b0}}, issue_i.imm};

    // immediate arithmetic and compares use the sign-extended immediate
    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::ADDI, ex_isa_pkg::ADDIU,
            ex_isa_pkg::SLTI, ex_isa_pkg::SLTIU: opb = imm_sx;
            default: opb = rt;
        endcase
    end

    assign is_sub = (issue_i.op == ex_isa_pkg::SUB) || (issue_i.op == ex_isa_pkg::SUBU);
    assign sum = is_sub ? rs - opb : rs + opb;

    // overflow when operand signs allow it and the result sign flips
    assign sign_cond = is_sub ? (rs[W-1] != opb[W-1]) : (rs[W-1] == opb[W-1]);
    assign trap_op = issue_i.op inside {ex_isa_pkg::ADD, ex_isa_pkg::SUB, ex_isa_pkg::ADDI};
    assign alu_overflow_o = trap_op && sign_cond && (sum[W-1] != rs[W-1]);

    assign slt_s = $signed(rs) < $signed(opb);
    assign slt_u = rs < opb;

    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::ADD, ex_isa_pkg::ADDU, ex_isa_pkg::SUB,
            ex_isa_pkg::SUBU, ex_isa_pkg::ADDI, ex_isa_pkg::ADDIU:
                alu_value_o = sum;
            ex_isa_pkg::SLT, ex_isa_pkg::SLTI:
                alu_value_o = {{(W-1){1'b0}}, slt_s};
            ex_isa_pkg::SLTU, ex_isa_pkg::SLTIU:
                alu_value_o = {{(W-1){1'b0}}, slt_u};
            ex_isa_pkg::AND:  alu_value_o = rs & rt;
            ex_isa_pkg::ANDI: alu_value_o = rs & imm_zx;
            ex_isa_pkg::OR:   alu_value_o = rs | rt;
            ex_isa_pkg::ORI:  alu_value_o = rs | imm_zx;
            ex_isa_pkg::XOR:  alu_value_o = rs ^ rt;
            ex_isa_pkg::XORI: alu_value_o = rs ^ imm_zx;
            ex_isa_pkg::NOR:  alu_value_o = ~(rs | rt);
            ex_isa_pkg::LUI:  alu_value_o = {issue_i.imm, {(W-IW){1'b0}}};
            // moves pass rs, the condition only gates the destination
            ex_isa_pkg::MOVZ, ex_isa_pkg::MOVN:
                alu_value_o = rs;
            default: alu_value_o = '0;
        endcase
    end

    // failed move condition, the write is dropped
    assign move_suppress_o = ((issue_i.op == ex_isa_pkg::MOVZ) && (rt != '0)) ||
                             ((issue_i.op == ex_isa_pkg::MOVN) && (rt == '0));

endmodule

// ==== hdl/ex_isa_pkg.sv ====
//****************************************************************************
// Execute-stage ISA definitions
// Word and field widths and the opcode set of the integer execute stage
//****************************************************************************
package ex_isa_pkg;

    // one machine word
    localparam int XLEN = 32;

    // instruction field widths
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W = 16;
    localparam int SHAMT_W = 5;
    localparam int OP_W = 8;

    // decoded opcodes handled by the stage
    typedef enum logic [OP_W-1:0] {
        NOP,
        // add, subtract, compare
        ADD, ADDU, SUB, SUBU, ADDI, ADDIU,
        SLT, SLTU, SLTI, SLTIU,
        // logical, LUI, conditional moves
        AND, ANDI, OR, ORI, XOR, XORI, NOR, LUI,
        MOVZ, MOVN,
        // shifts and bit counts
        SLL, SLLV, SRA, SRAV, SRL, SRLV,
        CLZ, CLO,
        // HI/LO access
        MFHI, MFLO, MTHI, MTLO,
        // multiply and accumulate
        MULT, MULTU, MUL, MADD, MADDU, MSUB, MSUBU,
        // iterative divide
        DIV, DIVU
    } ex_op_e;

endpackage

// ==== hdl/ex_muldiv.sv ====
//****************************************************************************
// Execute-stage multiply/divide unit
// HI/LO register, single-cycle multiply and accumulate, restoring divider
//****************************************************************************
`timescale 1ns/1ps

module ex_muldiv (
    input  logic                            clk,
    input  logic                            rst_n,
    input  ex_pipe_pkg::ex_issue_t          issue_i,
    input  logic                            accept_i,
    output logic [ex_isa_pkg::XLEN-1:0]     md_value_o,
    output logic                            busy_o
);

    localparam int W = ex_isa_pkg::XLEN;
    localparam int CNT_W = $clog2(W);

    typedef enum logic {
        IDLE,
        DIVIDE
    } div_state_e;

    div_state_e          state_q;
    logic [CNT_W-1:0]    step_q;
    ex_pipe_pkg::hilo_t  hilo_q;
    ex_pipe_pkg::hilo_t  hilo_d;
    logic [W-1:0]        rs;
    logic [W-1:0]        rt;
    logic                signed_mul;
    logic [2*W-1:0]      mul_a;
    logic [2*W-1:0]      mul_b;
    logic [2*W-1:0]      prod;
    logic                div_signed;
    logic                div_start;
    logic                last_step;
    logic [W-1:0]        rs_mag;
    logic [W-1:0]        rt_mag;
    logic [W-1:0]        quo_q;
    logic [W-1:0]        rem_q;
    logic [W-1:0]        dvsr_q;
    logic                quo_neg_q;
    logic                rem_neg_q;
    logic [W:0]          shifted;
    logic [W:0]          trial;
    logic [W-1:0]        quo_step;
    logic [W-1:0]        rem_step;
    logic [W-1:0]        quo_fix;
    logic [W-1:0]        rem_fix;

    assign rs = issue_i.rs_val;
    assign rt = issue_i.rt_val;

    // one 64-bit multiplier, signed forms extend the sign bits
    assign signed_mul = issue_i.op inside {ex_isa_pkg::MULT, ex_isa_pkg::MUL,
                                           ex_isa_pkg::MADD, ex_isa_pkg::MSUB};
    assign mul_a = {{W{signed_mul & rs[W-1]}}, rs};
    assign mul_b = {{W{signed_mul & rt[W-1]}}, rt};
    assign prod = mul_a * mul_b;

    always_comb
    begin
        hilo_d = hilo_q;
        case (issue_i.op)
            ex_isa_pkg::MTHI: hilo_d.hi = rs;
            ex_isa_pkg::MTLO: hilo_d.lo = rs;
            ex_isa_pkg::MULT, ex_isa_pkg::MULTU:
                hilo_d = ex_pipe_pkg::hilo_t'(prod);
            ex_isa_pkg::MADD, ex_isa_pkg::MADDU:
                hilo_d = ex_pipe_pkg::hilo_t'(hilo_q + prod);
            ex_isa_pkg::MSUB, ex_isa_pkg::MSUBU:
                hilo_d = ex_pipe_pkg::hilo_t'(hilo_q - prod);
            default: hilo_d = hilo_q;
        endcase
    end

    // divider works on magnitudes, signs fixed on the last step
    assign div_signed = issue_i.op == ex_isa_pkg::DIV;
    assign div_start = accept_i && (issue_i.op inside {ex_isa_pkg::DIV, ex_isa_pkg::DIVU});
    assign rs_mag = (div_signed && rs[W-1]) ? -rs : rs;
    assign rt_mag = (div_signed && rt[W-1]) ? -rt : rt;

    assign shifted = {rem_q, quo_q[W-1]};
    assign trial = shifted - {1'b0, dvsr_q};
    assign rem_step = trial[W] ? shifted[W-1:0] : trial[W-1:0];
    assign quo_step = {quo_q[W-2:0], ~trial[W]};
    assign quo_fix = quo_neg_q ? -quo_step : quo_step;
    assign rem_fix = rem_neg_q ? -rem_step : rem_step;

    assign last_step = (state_q == DIVIDE) && (step_q == CNT_W'(W - 1));
    assign busy_o = state_q == DIVIDE;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= IDLE;
            step_q <= '0;
            hilo_q <= '0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    if (accept_i)
                        hilo_q <= hilo_d;
                    if (div_start)
                    begin
                        state_q <= DIVIDE;
                        step_q <= '0;
                    end
                end
                DIVIDE:
                begin
                    step_q <= step_q + CNT_W'(1);
                    if (last_step)
                    begin
                        state_q <= IDLE;
                        hilo_q <= '{hi: rem_fix, lo: quo_fix};
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // divide by zero leaves the quotient all ones and unsigned
    always_ff @(posedge clk)
    begin
        if (div_start)
        begin
            quo_q <= rs_mag;
            rem_q <= '0;
            dvsr_q <= rt_mag;
            quo_neg_q <= div_signed && (rs[W-1] ^ rt[W-1]) && (rt != '0);
            rem_neg_q <= div_signed && rs[W-1];
        end
        else if (state_q == DIVIDE)
        begin
            quo_q <= quo_step;
            rem_q <= rem_step;
        end
    end

    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::MFHI: md_value_o = hilo_q.hi;
            ex_isa_pkg::MFLO: md_value_o = hilo_q.lo;
            ex_isa_pkg::MUL:  md_value_o = prod[W-1:0];
            default: md_value_o = '0;
        endcase
    end

    // the top level must hold issue while the divider runs
    a_no_accept_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> !accept_i);

endmodule

// ==== hdl/ex_pipe_pkg.sv ====
//****************************************************************************
// Execute-stage pipeline bundles
// Issue and writeback records and the HI/LO register pair
//****************************************************************************
package ex_pipe_pkg;

    // decoded instruction entering the stage
    typedef struct packed {
        logic                                valid;
        ex_isa_pkg::ex_op_e                  op;
        logic [ex_isa_pkg::XLEN-1:0]         rs_val;
        logic [ex_isa_pkg::XLEN-1:0]         rt_val;
        logic [ex_isa_pkg::IMM_W-1:0]        imm;
        logic [ex_isa_pkg::SHAMT_W-1:0]      shamt;
        logic [ex_isa_pkg::REG_ADDR_W-1:0]   rt_addr;
        logic [ex_isa_pkg::REG_ADDR_W-1:0]   rd_addr;
    } ex_issue_t;

    // registered result, dest of zero means no register write
    typedef struct packed {
        logic                                valid;
        logic [ex_isa_pkg::REG_ADDR_W-1:0]   dest;
        logic [ex_isa_pkg::XLEN-1:0]         value;
        logic                                overflow;
    } ex_wb_t;

    // multiply/divide result pair
    typedef struct packed {
        logic [ex_isa_pkg::XLEN-1:0]         hi;
        logic [ex_isa_pkg::XLEN-1:0]         lo;
    } hilo_t;

endpackage

// ==== hdl/ex_shift_count.sv ====
//****************************************************************************
// Execute-stage shifter and bit counter
// Logical/arithmetic shifts and leading-zero/leading-one counts
//****************************************************************************
`timescale 1ns/1ps

module ex_shift_count (
    input  ex_pipe_pkg::ex_issue_t          issue_i,
    output logic [ex_isa_pkg::XLEN-1:0]     sc_value_o
);

    localparam int W = ex_isa_pkg::XLEN;
    localparam int SW = ex_isa_pkg::SHAMT_W;
    localparam int CNT_W = $clog2(W) + 1;

    logic [SW-1:0]    amt;
    logic [CNT_W-1:0] lz_cnt;
    logic [CNT_W-1:0] lo_cnt;

    // zeros above the first set bit, W for an all-zero word
    function automatic logic [CNT_W-1:0] lead_zeros(input logic [W-1:0] word);
        logic [CNT_W-1:0] n;
        logic             found;
        n = '0;
        found = 1'b0;
        for (int i = W - 1; i >= 0; i--)
        begin
            if (word[i])
                found = 1'b1;
            else if (!found)
                n = n + CNT_W'(1);
        end
        return n;
    endfunction

    // variable forms shift by the low bits of rs
    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::SLLV, ex_isa_pkg::SRLV, ex_isa_pkg::SRAV:
                amt = issue_i.rs_val[SW-1:0];
            default: amt = issue_i.shamt;
        endcase
    end

    assign lz_cnt = lead_zeros(issue_i.rs_val);
    assign lo_cnt = lead_zeros(~issue_i.rs_val);

    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::SLL, ex_isa_pkg::SLLV: sc_value_o = issue_i.rt_val << amt;
            ex_isa_pkg::SRL, ex_isa_pkg::SRLV: sc_value_o = issue_i.rt_val >> amt;
            ex_isa_pkg::SRA, ex_isa_pkg::SRAV: sc_value_o = $signed(issue_i.rt_val) >>> amt;
            ex_isa_pkg::CLZ: sc_value_o = {{(W-CNT_W){1'b0}}, lz_cnt};
            ex_isa_pkg::CLO: sc_value_o = {{(W-CNT_W){1'b0}}, lo_cnt};
            default: sc_value_o = '0;
        endcase
    end

endmodule

// ==== hdl/ex_unit.sv ====
//****************************************************************************
// Integer execute stage
// Result and destination select, registered writeback, divide stall
//****************************************************************************
`timescale 1ns/1ps

module ex_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ex_pipe_pkg::ex_issue_t  issue_i,
    output logic                    stall_o,
    output ex_pipe_pkg::ex_wb_t     wb_o
);

    localparam int W = ex_isa_pkg::XLEN;

    logic                                accept;
    logic                                busy;
    logic                                alu_overflow;
    logic                                move_suppress;
    logic                                writes_reg;
    logic                                imm_dest;
    logic [W-1:0]                        alu_value;
    logic [W-1:0]                        sc_value;
    logic [W-1:0]                        md_value;
    logic [W-1:0]                        result;
    logic [ex_isa_pkg::REG_ADDR_W-1:0]   dest;
    ex_pipe_pkg::ex_wb_t                 wb_q;

    assign accept = issue_i.valid && !busy;

    ex_alu u_alu (
        .issue_i         (issue_i),
        .alu_value_o     (alu_value),
        .alu_overflow_o  (alu_overflow),
        .move_suppress_o (move_suppress)
    );

    ex_shift_count u_shift_count (
        .issue_i    (issue_i),
        .sc_value_o (sc_value)
    );

    ex_muldiv u_muldiv (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_i    (issue_i),
        .accept_i   (accept),
        .md_value_o (md_value),
        .busy_o     (busy)
    );

    always_comb
    begin
        case (issue_i.op)
            ex_isa_pkg::SLL, ex_isa_pkg::SLLV, ex_isa_pkg::SRA, ex_isa_pkg::SRAV,
            ex_isa_pkg::SRL, ex_isa_pkg::SRLV, ex_isa_pkg::CLZ, ex_isa_pkg::CLO:
                result = sc_value;
            ex_isa_pkg::MFHI, ex_isa_pkg::MFLO, ex_isa_pkg::MUL:
                result = md_value;
            default: result = alu_value;
        endcase
    end

    // HI/LO-only ops and NOP leave the register file alone
    assign writes_reg = !(issue_i.op inside {ex_isa_pkg::NOP, ex_isa_pkg::MTHI,
        ex_isa_pkg::MTLO, ex_isa_pkg::MULT, ex_isa_pkg::MULTU, ex_isa_pkg::MADD,
        ex_isa_pkg::MADDU, ex_isa_pkg::MSUB, ex_isa_pkg::MSUBU, ex_isa_pkg::DIV,
        ex_isa_pkg::DIVU});
    assign imm_dest = issue_i.op inside {ex_isa_pkg::ADDI, ex_isa_pkg::ADDIU,
        ex_isa_pkg::SLTI, ex_isa_pkg::SLTIU, ex_isa_pkg::ANDI, ex_isa_pkg::ORI,
        ex_isa_pkg::XORI, ex_isa_pkg::LUI};

    // trapped overflow or a failed move still reports, but writes nothing
    assign dest = (alu_overflow || move_suppress) ? '0 :
                  imm_dest ? issue_i.rt_addr : issue_i.rd_addr;

    always_ff @(posedge clk)
    begin
        wb_q.dest <= dest;
        wb_q.value <= result;
        wb_q.overflow <= accept && alu_overflow;
        if (!rst_n)
            wb_q.valid <= 1'b0;
        else
            wb_q.valid <= accept && writes_reg;
    end

    assign wb_o = wb_q;
    assign stall_o = busy;

    a_ovf_no_dest: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_o.valid && wb_o.overflow) |-> (wb_o.dest == '0));

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the execute-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ex_unit_tb
./obj_dir/Vex_unit_tb | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1

// ==== verilog.f ====
+incdir+dv
hdl/ex_isa_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_shift_count.sv
hdl/ex_muldiv.sv
hdl/ex_unit.sv
dv/ex_unit_tb.sv
